//--- hw/cp15_map_pkg.sv
package cp15_map_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [2:0]  cp_opcode;

	// ##############################
	// Register numbers
	// ##############################

	localparam reg_num CRN_CPUID  = 4'd0;
	localparam reg_num CRN_SYSCFG = 4'd1;
	localparam reg_num CRN_TTBR   = 4'd2;
	localparam reg_num CRN_DOMAIN = 4'd3;
	localparam reg_num CRN_FSR    = 4'd5;
	localparam reg_num CRN_FAR    = 4'd6;

	localparam logic [3:0] CP15_NUM = 4'd15;

	// Class bits 27:24, coprocessor number and bit 4 of an MCR/MRC
	localparam word CP_CLASS_MASK = 32'h0F00_0F10;
	localparam word CP15_CLASS    = {8'h0E, 12'h000, CP15_NUM, 8'h10};

	typedef struct packed {
		logic [3:0] cond;
		logic [3:0] class_hi;      // 4'b1110 for register transfers
		cp_opcode   op1;
		logic       load;          // Set for MRC
		reg_num     crn;
		logic [3:0] rd;
		logic [3:0] cp_num;
		cp_opcode   op2;
		logic       class_lo;
		reg_num     crm;
	} coproc_fields;

	typedef union packed {
		word          raw;
		coproc_fields f;
	} coproc_insn;

	typedef struct packed {
		reg_num   crn;
		reg_num   crm;
		cp_opcode op1;
		cp_opcode op2;
		logic     load;
	} coproc_decode;

endpackage

//--- hw/mmu_format_pkg.sv
package mmu_format_pkg;

	typedef logic [29:0] ptr;           // Word address
	typedef logic [17:0] mmu_base;      // Table base, bits 31:14

	typedef logic [15:0][1:0] domain_ctrl;

	typedef struct packed {
		logic [3:0] domain;
		logic [3:0] status;
	} fault_status;

	// ##############################
	// System control register
	// ##############################

	typedef struct packed {
		logic [31:14] rsvd_hi;
		logic         v;            // High vectors
		logic [12:2]  rsvd_mid;
		logic         a;            // Alignment check
		logic         m;            // MMU enable
	} syscfg_ctrl;

endpackage

//--- hw/core_cp15_decode.sv
module core_cp15_decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       cp_valid,
	input  cp15_map_pkg::coproc_insn   insn,
	input  cp15_map_pkg::word          read,
	output logic                       transfer,
	output cp15_map_pkg::coproc_decode dec,
	output cp15_map_pkg::word          read_data,
	output logic                       read_valid,
	output logic                       undef
);

	import cp15_map_pkg::*;

	logic is_cp15;
	logic crn_impl;
	logic writes_ro;

	assign is_cp15 = (insn.raw & CP_CLASS_MASK) == CP15_CLASS;

	always_comb begin
		unique case (insn.f.crn)
			CRN_CPUID, CRN_SYSCFG, CRN_TTBR, CRN_DOMAIN, CRN_FSR, CRN_FAR:
				crn_impl = 1'b1;
			default:
				crn_impl = 1'b0;
		endcase
	end

	assign writes_ro = insn.f.crn == CRN_CPUID && !insn.f.load;    // MCR to CPU ID

	assign transfer = cp_valid && is_cp15 && crn_impl && !writes_ro;

	assign dec = '{
		crn:  insn.f.crn,
		crm:  insn.f.crm,
		op1:  insn.f.op1,
		op2:  insn.f.op2,
		load: insn.f.load
	};

	// ##############################
	// Response one cycle later
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_valid <= 1'b0;
			undef      <= 1'b0;
		end else begin
			read_valid <= transfer && dec.load;
			undef      <= cp_valid && !transfer;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			read_data <= '0;
		else if (transfer && dec.load)
			read_data <= read;
	end

	a_insn_known: assert property (@(posedge clk) disable iff (!rst_n)
		cp_valid |-> !$isunknown(insn.raw));

endmodule

//--- hw/core_cp15_syscfg.sv
module core_cp15_syscfg (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       transfer,
	input  cp15_map_pkg::coproc_decode dec,
	input  cp15_map_pkg::word          write,
	output cp15_map_pkg::word          read,
	output logic                       mmu_enable,
	output logic                       high_vectors,
	output logic                       align_check
);

	import mmu_format_pkg::*;

	syscfg_ctrl ctrl;
	syscfg_ctrl wr;

	assign wr = write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ctrl <= '0;
		else if (transfer && !dec.load)
			ctrl <= '{m: wr.m, a: wr.a, v: wr.v, default: '0};    // Implemented bits only
	end

	assign read = ctrl;

	assign mmu_enable   = ctrl.m;
	assign align_check  = ctrl.a;
	assign high_vectors = ctrl.v;

	a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({mmu_enable, high_vectors, align_check}));

endmodule

//--- hw/core_cp15_mmu_regs.sv
module core_cp15_mmu_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       transfer_ttbr,
	input  logic                       transfer_domain,
	input  cp15_map_pkg::coproc_decode dec,
	input  cp15_map_pkg::word          write,
	output cp15_map_pkg::word          read_ttbr,
	output cp15_map_pkg::word          read_domain,
	output mmu_format_pkg::mmu_base    mmu_ttbr,
	output mmu_format_pkg::domain_ctrl domains
);

	import mmu_format_pkg::*;

	mmu_base    ttbr;
	domain_ctrl dac;

	// ##############################
	// Translation table base
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ttbr <= '0;
		else if (transfer_ttbr && !dec.load)
			ttbr <= write[31:14];
	end

	assign read_ttbr = {ttbr, 14'b0};
	assign mmu_ttbr  = ttbr;

	// ##############################
	// Domain access control
	// ##############################

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dac <= '0;
		else if (transfer_domain && !dec.load)
			dac <= write;
	end

	assign read_domain = dac;
	assign domains     = dac;

endmodule

//--- hw/core_cp15_fault.sv
module core_cp15_fault (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        transfer_fsr,
	input  logic                        transfer_far,
	input  cp15_map_pkg::coproc_decode  dec,
	input  cp15_map_pkg::word           write,
	input  logic                        fault_register,
	input  mmu_format_pkg::ptr          fault_addr,
	input  mmu_format_pkg::fault_status fault_status_in,
	output cp15_map_pkg::word           read_fsr,
	output cp15_map_pkg::word           read_far
);

	import mmu_format_pkg::*;

	ptr          far_q;
	fault_status fsr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			far_q <= '0;
			fsr_q <= '0;
		end else if (fault_register) begin    // Abort capture beats software
			far_q <= fault_addr;
			fsr_q <= fault_status_in;
		end else begin
			if (transfer_far && !dec.load)
				far_q <= write[31:2];
			if (transfer_fsr && !dec.load)
				fsr_q <= write[7:0];
		end
	end

	assign read_far = {far_q, 2'b00};    // Byte address
	assign read_fsr = {24'b0, fsr_q};

	a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		fault_register |-> !$isunknown(fault_addr));

endmodule

//--- hw/core_cp15.sv
module core_cp15 #(
	parameter cp15_map_pkg::word CPUID = 32'h4107_9200
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        transfer,
	input  cp15_map_pkg::coproc_decode  dec,
	input  cp15_map_pkg::word           write,
	input  logic                        fault_register,
	input  mmu_format_pkg::ptr          fault_addr,
	input  mmu_format_pkg::fault_status fault_status_in,
	output cp15_map_pkg::word           read,
	output logic                        mmu_enable,
	output logic                        high_vectors,
	output logic                        align_check,
	output mmu_format_pkg::mmu_base     mmu_ttbr,
	output mmu_format_pkg::domain_ctrl  domains
);

	import cp15_map_pkg::*;

	logic transfer_syscfg;
	logic transfer_ttbr;
	logic transfer_domain;
	logic transfer_fsr;
	logic transfer_far;

	word read_syscfg;
	word read_ttbr;
	word read_domain;
	word read_fsr;
	word read_far;

	assign transfer_syscfg = transfer && dec.crn == CRN_SYSCFG;
	assign transfer_ttbr   = transfer && dec.crn == CRN_TTBR;
	assign transfer_domain = transfer && dec.crn == CRN_DOMAIN;
	assign transfer_fsr    = transfer && dec.crn == CRN_FSR;
	assign transfer_far    = transfer && dec.crn == CRN_FAR;

	core_cp15_syscfg syscfg (
		.read(read_syscfg),
		.transfer(transfer_syscfg),
		.*
	);

	core_cp15_mmu_regs mmu_regs (.*);

	core_cp15_fault fault (.*);

	// ##############################
	// Read mux
	// ##############################

	always_comb begin
		unique case (dec.crn)
			CRN_CPUID:  read = CPUID;
			CRN_SYSCFG: read = read_syscfg;
			CRN_TTBR:   read = read_ttbr;
			CRN_DOMAIN: read = read_domain;
			CRN_FSR:    read = read_fsr;
			CRN_FAR:    read = read_far;
			default:    read = '0;      // Unimplemented
		endcase
	end

endmodule

//--- hw/core_cp15_top.sv
module core_cp15_top #(
	parameter cp15_map_pkg::word CPUID = 32'h4107_9200
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cp_valid,
	input  cp15_map_pkg::coproc_insn    insn,
	input  cp15_map_pkg::word           write,
	input  logic                        fault_register,
	input  mmu_format_pkg::ptr          fault_addr,
	input  mmu_format_pkg::fault_status fault_status_in,
	output cp15_map_pkg::word           read_data,
	output logic                        read_valid,
	output logic                        undef,
	output logic                        mmu_enable,
	output logic                        high_vectors,
	output logic                        align_check,
	output mmu_format_pkg::mmu_base     mmu_ttbr,
	output mmu_format_pkg::domain_ctrl  domains
);

	import cp15_map_pkg::*;

	logic         transfer;
	coproc_decode dec;
	word          read;

	core_cp15_decode decode (.*);

	core_cp15 #(
		.CPUID(CPUID)
	) cp15 (.*);

endmodule

//--- dv/core_cp15_tb.sv
module core_cp15_tb;

	import cp15_map_pkg::*;
	import mmu_format_pkg::*;

	localparam word TEST_CPUID   = 32'h4115_a3c5;
	localparam int  DRIVE_DELAY  = 10;
	localparam int  READ_TIMEOUT = 20;

	logic        clk;
	logic        rst_n;
	logic        cp_valid;
	coproc_insn  insn;
	word         write;
	logic        fault_register;
	ptr          fault_addr;
	fault_status fault_status_in;
	word         read_data;
	logic        read_valid;
	logic        undef;
	logic        mmu_enable;
	logic        high_vectors;
	logic        align_check;
	mmu_base     mmu_ttbr;
	domain_ctrl  domains;

	word syscfg_shadow;    // Last control value written
	word ttbr_shadow;

	core_cp15_top #(
		.CPUID(TEST_CPUID)
	) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ##############################
	// Checks
	// ##############################

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word got, input word exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_base(input string name, input mmu_base got, input mmu_base exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// ##############################
	// Bus tasks
	// ##############################

	// MCR/MRC encoding, Rd and opcodes at zero
	function automatic coproc_insn make_insn(input logic load, input reg_num crn,
			input logic [3:0] cp_num);
		coproc_insn i;
		i.raw      = '0;
		i.f.cond   = 4'hE;
		i.f.class_hi = 4'b1110;
		i.f.load   = load;
		i.f.crn    = crn;
		i.f.cp_num = cp_num;
		i.f.class_lo = 1'b1;
		return i;
	endfunction

	task automatic cp_write(input reg_num crn, input word data);
		insn     = make_insn(1'b0, crn, CP15_NUM);
		write    = data;
		cp_valid = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		cp_valid = 1'b0;
		check_flag("undef", undef, 1'b0);
	endtask

	task automatic cp_read(input reg_num crn, output word data);
		int waited;
		insn     = make_insn(1'b1, crn, CP15_NUM);
		cp_valid = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		cp_valid = 1'b0;
		waited   = 1;
		while (!read_valid && waited < READ_TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
		end
		if (!read_valid) begin
			$display("Timed out waiting for read_valid on a read of CRn %0d", crn);
			stop_run();
		end
		if (waited != 1) begin
			$display("Read of CRn %0d answered after %0d cycles instead of one", crn, waited);
			stop_run();
		end
		data = read_data;
	endtask

	task automatic send_undefined(input coproc_insn bad, input word data);
		insn     = bad;
		write    = data;
		cp_valid = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		cp_valid = 1'b0;
		check_flag("undef", undef, 1'b1);
		check_flag("read_valid", read_valid, 1'b0);
	endtask

	task automatic abort(input ptr addr, input fault_status st);
		fault_register  = 1'b1;
		fault_addr      = addr;
		fault_status_in = st;
		@(posedge clk);
		#DRIVE_DELAY;
		fault_register = 1'b0;
	endtask

	// ##############################
	// Tests
	// ##############################

	task automatic test_reset_state();
		word data;
		check_flag("mmu_enable", mmu_enable, 1'b0);
		check_flag("high_vectors", high_vectors, 1'b0);
		check_flag("read_valid", read_valid, 1'b0);
		check_flag("undef", undef, 1'b0);
		cp_read(CRN_CPUID, data);
		check_word("cpuid", data, TEST_CPUID);
		cp_read(CRN_SYSCFG, data);
		check_word("syscfg", data, 32'h0);
	endtask

	task automatic test_control();
		word w;
		word data;
		repeat (6) begin
			w = $urandom;
			cp_write(CRN_SYSCFG, w);
			check_flag("mmu_enable", mmu_enable, w[0]);
			check_flag("align_check", align_check, w[1]);
			check_flag("high_vectors", high_vectors, w[13]);
			cp_read(CRN_SYSCFG, data);
			check_word("syscfg", data, w & 32'h0000_2003);    // M, A and V only
			syscfg_shadow = w & 32'h0000_2003;
		end
	endtask

	task automatic test_mmu_regs();
		word w;
		word data;
		w = $urandom;
		cp_write(CRN_TTBR, w);
		check_base("mmu_ttbr", mmu_ttbr, w[31:14]);
		cp_read(CRN_TTBR, data);
		check_word("ttbr", data, {w[31:14], 14'b0});
		ttbr_shadow = {w[31:14], 14'b0};
		w = $urandom;
		cp_write(CRN_DOMAIN, w);
		check_word("domains", 32'(domains), w);
		cp_read(CRN_DOMAIN, data);
		check_word("domain", data, w);
	endtask

	task automatic test_abort();
		ptr          addr;
		fault_status st;
		word         w;
		word         data;
		addr = ptr'($urandom);
		st   = 8'($urandom);
		abort(addr, st);
		cp_read(CRN_FAR, data);
		check_word("far", data, {addr, 2'b00});
		cp_read(CRN_FSR, data);
		check_word("fsr", data, {24'h0, st});
		// Software write to FSR in the capture cycle
		w    = $urandom;
		addr = ptr'($urandom);
		st   = ~w[7:0];
		insn            = make_insn(1'b0, CRN_FSR, CP15_NUM);
		write           = w;
		cp_valid        = 1'b1;
		fault_register  = 1'b1;
		fault_addr      = addr;
		fault_status_in = st;
		@(posedge clk);
		#DRIVE_DELAY;
		cp_valid       = 1'b0;
		fault_register = 1'b0;
		check_flag("undef", undef, 1'b0);
		cp_read(CRN_FSR, data);
		check_word("fsr", data, {24'h0, st});
		cp_read(CRN_FAR, data);
		check_word("far", data, {addr, 2'b00});
	endtask

	task automatic test_undefined();
		word data;
		send_undefined(make_insn(1'b0, CRN_SYSCFG, 4'd14), ~syscfg_shadow);
		send_undefined(make_insn(1'b0, 4'd4, CP15_NUM), $urandom);    // No CRn 4
		send_undefined(make_insn(1'b0, CRN_CPUID, CP15_NUM), ~TEST_CPUID);
		send_undefined(make_insn(1'b0, CRN_TTBR, 4'd14), ~ttbr_shadow);
		cp_read(CRN_SYSCFG, data);
		check_word("syscfg", data, syscfg_shadow);
		cp_read(CRN_TTBR, data);
		check_word("ttbr", data, ttbr_shadow);
		cp_read(CRN_CPUID, data);
		check_word("cpuid", data, TEST_CPUID);
	endtask

	initial begin
		void'($urandom(32'h1a82_fe07));
		rst_n           = 1'b0;
		cp_valid        = 1'b0;
		insn            = '0;
		write           = '0;
		fault_register  = 1'b0;
		fault_addr      = '0;
		fault_status_in = '0;
		syscfg_shadow   = '0;
		ttbr_shadow     = '0;
		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		test_reset_state();
		test_control();
		test_mmu_regs();
		test_abort();
		test_undefined();
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- list.f
hw/cp15_map_pkg.sv
hw/mmu_format_pkg.sv
hw/core_cp15_decode.sv
hw/core_cp15_syscfg.sv
hw/core_cp15_mmu_regs.sv
hw/core_cp15_fault.sv
hw/core_cp15.sv
hw/core_cp15_top.sv
dv/core_cp15_tb.sv

//--- Makefile
SIM_BIN := core_cp15_sim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module core_cp15_top

sim:
	verilator --binary --timing --assert -f list.f --top-module core_cp15_tb -o $(SIM_BIN)
	@out="$$(./obj_dir/$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
